/* build.f */
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_fetch.sv
logic/rv_execute.sv
logic/rv_memory.sv
logic/rv_core_top.sv
verif/tb_top.sv

/* logic/rv_alu.sv */
// no arithmetic right shift and no unsigned compare; shift amount is b_i[4:0]
`timescale 1ns/100ps

module rv_alu (
   input  logic [rv_pkg::XLEN-1:0] a_i,
   input  logic [rv_pkg::XLEN-1:0] b_i,
   input  rv_pkg::alu_op_e         op_i,
   output logic [rv_pkg::XLEN-1:0] result_o
);

   import rv_pkg::*;

   logic [4:0] shamt;
   logic       lt;

   assign shamt = b_i[4:0];
   assign lt    = $signed(a_i) < $signed(b_i);

   always_comb begin
      case (op_i)
         ALU_ADD:    result_o = a_i + b_i;
         ALU_SUB:    result_o = a_i - b_i;
         ALU_AND:    result_o = a_i & b_i;
         ALU_OR:     result_o = a_i | b_i;
         ALU_XOR:    result_o = a_i ^ b_i;
         ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt};
         ALU_SLL:    result_o = a_i << shamt;
         ALU_SRL:    result_o = a_i >> shamt;
         ALU_PASS_B: result_o = b_i;
         default:    result_o = '0;
      endcase
   end

endmodule

/* logic/rv_core_top.sv */
// load memories over apb with run_i low; allow two idle cycles after run_i falls before readback
`timescale 1ns/100ps

module rv_core_top #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic                      clk_i,
   input  logic                      t_intr,
   input  logic                      run_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  logic [rv_pkg::APB_AW-1:0] paddr_i,
   input  logic [rv_pkg::XLEN-1:0]   pwdata_i,
   output logic [rv_pkg::XLEN-1:0]   prdata_o,
   output logic                      pready_o
);

   import rv_pkg::*;

   logic [XLEN-1:0]   instr_d;
   logic [XLEN-1:0]   pc_d;
   logic              redirect;
   logic [XLEN-1:0]   redirect_pc;
   logic [XLEN-1:0]   alu_m;
   logic [XLEN-1:0]   store_data_m;
   logic [REG_AW-1:0] rd_m;
   logic              reg_write_m;
   logic              mem_write_m;
   wb_sel_e           wb_sel_m;
   logic [XLEN-1:0]   pc4_m;
   logic              wb_we;
   logic [REG_AW-1:0] wb_rd;
   logic [XLEN-1:0]   wb_data;
   logic              imem_we;
   logic [APB_AW-5:0] imem_waddr;
   logic [XLEN-1:0]   imem_wdata;

   rv_fetch #(
      .IMEM_WORDS (IMEM_WORDS)
   ) u_fetch (
      .clk_i         (clk_i),
      .t_intr        (t_intr),
      .run_i         (run_i),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .imem_we_i     (imem_we),
      .imem_waddr_i  (imem_waddr),
      .imem_wdata_i  (imem_wdata),
      .instr_d_o     (instr_d),
      .pc_d_o        (pc_d)
   );

   rv_execute u_execute (
      .clk_i          (clk_i),
      .t_intr         (t_intr),
      .instr_d_i      (instr_d),
      .pc_d_i         (pc_d),
      .wb_we_i        (wb_we),
      .wb_rd_i        (wb_rd),
      .wb_data_i      (wb_data),
      .redirect_o     (redirect),
      .redirect_pc_o  (redirect_pc),
      .alu_m_o        (alu_m),
      .store_data_m_o (store_data_m),
      .rd_m_o         (rd_m),
      .reg_write_m_o  (reg_write_m),
      .mem_write_m_o  (mem_write_m),
      .wb_sel_m_o     (wb_sel_m),
      .pc4_m_o        (pc4_m)
   );

   rv_memory #(
      .DMEM_WORDS (DMEM_WORDS)
   ) u_memory (
      .clk_i          (clk_i),
      .t_intr         (t_intr),
      .run_i          (run_i),
      .alu_m_i        (alu_m),
      .store_data_m_i (store_data_m),
      .rd_m_i         (rd_m),
      .reg_write_m_i  (reg_write_m),
      .mem_write_m_i  (mem_write_m),
      .wb_sel_m_i     (wb_sel_m),
      .pc4_m_i        (pc4_m),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .wb_we_o        (wb_we),
      .wb_rd_o        (wb_rd),
      .wb_data_o      (wb_data),
      .imem_we_o      (imem_we),
      .imem_waddr_o   (imem_waddr),
      .imem_wdata_o   (imem_wdata),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o)
   );

endmodule

/* logic/rv_decoder.sv */
// rv32i subset only; every other encoding decodes to a no-op with no register or memory write
`timescale 1ns/100ps

module rv_decoder (
   input  logic [rv_pkg::XLEN-1:0]   instr_i,
   output logic [rv_pkg::REG_AW-1:0] rs1_o,
   output logic [rv_pkg::REG_AW-1:0] rs2_o,
   output logic [rv_pkg::REG_AW-1:0] rd_o,
   output logic [rv_pkg::XLEN-1:0]   imm_o,
   output rv_pkg::alu_op_e           alu_op_o,
   output logic                      alu_src_imm_o,
   output logic                      reg_write_o,
   output logic                      mem_write_o,
   output rv_pkg::wb_sel_e           wb_sel_o,
   output rv_pkg::br_kind_e          br_kind_o,
   output logic                      jal_o
);

   import rv_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic       f7b5;

   assign opcode = opcode_e'(instr_i[6:0]);
   assign funct3 = instr_i[14:12];
   assign f7b5   = instr_i[30];
   assign rs1_o  = instr_i[19:15];
   assign rs2_o  = instr_i[24:20];
   assign rd_o   = instr_i[11:7];

   always_comb begin
      alu_op_o      = ALU_ADD;
      alu_src_imm_o = 1'b0;
      reg_write_o   = 1'b0;
      mem_write_o   = 1'b0;
      wb_sel_o      = WB_ALU;
      br_kind_o     = BR_NONE;
      jal_o         = 1'b0;
      imm_o         = '0;
      case (opcode)
         OPC_OP: begin
            reg_write_o = 1'b1;
            case (funct3)
               3'b000: alu_op_o = f7b5 ? ALU_SUB : ALU_ADD;
               3'b111: alu_op_o = ALU_AND;
               3'b110: alu_op_o = ALU_OR;
               3'b100: alu_op_o = ALU_XOR;
               3'b010: alu_op_o = ALU_SLT;
               3'b001: alu_op_o = ALU_SLL;
               3'b101: begin
                  alu_op_o    = ALU_SRL;
                  reg_write_o = !f7b5;   // sra not supported
               end
               default: reg_write_o = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin
            reg_write_o   = 1'b1;
            alu_src_imm_o = 1'b1;
            imm_o         = {{20{instr_i[31]}}, instr_i[31:20]};
            case (funct3)
               3'b000: alu_op_o = ALU_ADD;
               3'b111: alu_op_o = ALU_AND;
               3'b110: alu_op_o = ALU_OR;
               3'b100: alu_op_o = ALU_XOR;
               3'b010: alu_op_o = ALU_SLT;
               default: reg_write_o = 1'b0;   // immediate shifts dropped
            endcase
         end
         OPC_LUI: begin
            reg_write_o   = 1'b1;
            alu_src_imm_o = 1'b1;
            alu_op_o      = ALU_PASS_B;
            imm_o         = {instr_i[31:12], 12'b0};
         end
         OPC_LOAD: begin
            reg_write_o   = (funct3 == 3'b010);   // lw only
            alu_src_imm_o = 1'b1;
            wb_sel_o      = WB_MEM;
            imm_o         = {{20{instr_i[31]}}, instr_i[31:20]};
         end
         OPC_STORE: begin
            mem_write_o   = (funct3 == 3'b010);   // sw only
            alu_src_imm_o = 1'b1;
            imm_o         = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
         end
         OPC_BRANCH: begin
            imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
            case (funct3)
               3'b000: br_kind_o = BR_EQ;
               3'b001: br_kind_o = BR_NE;
               3'b100: br_kind_o = BR_LT;
               default: br_kind_o = BR_NONE;
            endcase
         end
         OPC_JAL: begin
            jal_o       = 1'b1;
            reg_write_o = 1'b1;
            wb_sel_o    = WB_PC4;   // link value
            imm_o       = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                           instr_i[30:21], 1'b0};
         end
         default: ;
      endcase
   end

endmodule

/* logic/rv_execute.sv */
// forwards only from writeback, enough here since data memory reads are combinational
`timescale 1ns/100ps

module rv_execute (
   input  logic                      clk_i,
   input  logic                      t_intr,
   input  logic [rv_pkg::XLEN-1:0]   instr_d_i,
   input  logic [rv_pkg::XLEN-1:0]   pc_d_i,
   input  logic                      wb_we_i,
   input  logic [rv_pkg::REG_AW-1:0] wb_rd_i,
   input  logic [rv_pkg::XLEN-1:0]   wb_data_i,
   output logic                      redirect_o,
   output logic [rv_pkg::XLEN-1:0]   redirect_pc_o,
   output logic [rv_pkg::XLEN-1:0]   alu_m_o,
   output logic [rv_pkg::XLEN-1:0]   store_data_m_o,
   output logic [rv_pkg::REG_AW-1:0] rd_m_o,
   output logic                      reg_write_m_o,
   output logic                      mem_write_m_o,
   output rv_pkg::wb_sel_e           wb_sel_m_o,
   output logic [rv_pkg::XLEN-1:0]   pc4_m_o
);

   import rv_pkg::*;

   logic [REG_AW-1:0] rs1;
   logic [REG_AW-1:0] rs2;
   logic [REG_AW-1:0] rd;
   logic [XLEN-1:0]   imm;
   alu_op_e           alu_op;
   logic              alu_src_imm;
   logic              reg_write;
   logic              mem_write;
   wb_sel_e           wb_sel;
   br_kind_e          br_kind;
   logic              jal;
   logic [XLEN-1:0]   rdata1;
   logic [XLEN-1:0]   rdata2;
   logic [XLEN-1:0]   op_a;
   logic [XLEN-1:0]   op_b;
   logic [XLEN-1:0]   alu_res;
   logic              br_taken;

   rv_decoder u_decoder (
      .instr_i       (instr_d_i),
      .rs1_o         (rs1),
      .rs2_o         (rs2),
      .rd_o          (rd),
      .imm_o         (imm),
      .alu_op_o      (alu_op),
      .alu_src_imm_o (alu_src_imm),
      .reg_write_o   (reg_write),
      .mem_write_o   (mem_write),
      .wb_sel_o      (wb_sel),
      .br_kind_o     (br_kind),
      .jal_o         (jal)
   );

   rv_regfile u_regfile (
      .clk_i    (clk_i),
      .t_intr   (t_intr),
      .we_i     (wb_we_i),
      .waddr_i  (wb_rd_i),
      .wdata_i  (wb_data_i),
      .raddr1_i (rs1),
      .raddr2_i (rs2),
      .rdata1_o (rdata1),
      .rdata2_o (rdata2)
   );

   // writeback lands at the same edge, so bypass it
   assign op_a = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs1) ? wb_data_i : rdata1;
   assign op_b = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs2) ? wb_data_i : rdata2;

   rv_alu u_alu (
      .a_i      (op_a),
      .b_i      (alu_src_imm ? imm : op_b),
      .op_i     (alu_op),
      .result_o (alu_res)
   );

   always_comb begin
      case (br_kind)
         BR_EQ:   br_taken = (op_a == op_b);
         BR_NE:   br_taken = (op_a != op_b);
         BR_LT:   br_taken = ($signed(op_a) < $signed(op_b));
         default: br_taken = 1'b0;
      endcase
   end

   assign redirect_o    = br_taken || jal;
   assign redirect_pc_o = pc_d_i + imm;   // own adder, alu stays free

   // execute/memory register
   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         reg_write_m_o <= 1'b0;
         mem_write_m_o <= 1'b0;
         wb_sel_m_o    <= WB_ALU;
      end else begin
         reg_write_m_o <= reg_write;
         mem_write_m_o <= mem_write;
         wb_sel_m_o    <= wb_sel;
      end
   end

   always_ff @(posedge clk_i) begin
      alu_m_o        <= alu_res;
      store_data_m_o <= op_b;
      rd_m_o         <= rd;
      pc4_m_o        <= pc_d_i + XLEN'(4);
   end

endmodule

/* logic/rv_fetch.sv */
// imem is read combinationally at the pc, so it maps to distributed ram; IMEM_WORDS power of two
`timescale 1ns/100ps

module rv_fetch #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                     clk_i,
   input  logic                     t_intr,
   input  logic                     run_i,
   input  logic                     redirect_i,
   input  logic [rv_pkg::XLEN-1:0]  redirect_pc_i,
   input  logic                     imem_we_i,
   input  logic [rv_pkg::APB_AW-5:0] imem_waddr_i,   // apb word index
   input  logic [rv_pkg::XLEN-1:0]  imem_wdata_i,
   output logic [rv_pkg::XLEN-1:0]  instr_d_o,
   output logic [rv_pkg::XLEN-1:0]  pc_d_o
);

   import rv_pkg::*;

   localparam int IDX_W = $clog2(IMEM_WORDS);

   logic [XLEN-1:0] imem [IMEM_WORDS];
   logic [XLEN-1:0] pc_q;
   logic [XLEN-1:0] pc_next;
   logic [XLEN-1:0] instr_f;

   assign instr_f = imem[pc_q[IDX_W+1:2]];   // low pc bits ignored
   assign pc_next = redirect_i ? redirect_pc_i : pc_q + XLEN'(4);

   // loaded over apb while the core is halted
   always_ff @(posedge clk_i) begin
      if (imem_we_i) begin
         imem[imem_waddr_i[IDX_W-1:0]] <= imem_wdata_i;
      end
   end

   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         pc_q <= '0;
      end else if (run_i) begin
         pc_q <= pc_next;
      end
   end

   // fetch/decode register, bubble on redirect or halt
   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         instr_d_o <= NOP_INSTR;
      end else if (redirect_i || !run_i) begin
         instr_d_o <= NOP_INSTR;   // kills the wrong-path fetch
      end else begin
         instr_d_o <= instr_f;
      end
   end

   always_ff @(posedge clk_i) begin
      pc_d_o <= pc_q;
   end

endmodule

/* logic/rv_memory.sv */
// word accesses only, no alignment check; apb transfers complete only while run_i is low
`timescale 1ns/100ps

module rv_memory #(
   parameter int DMEM_WORDS = 256
) (
   input  logic                      clk_i,
   input  logic                      t_intr,
   input  logic                      run_i,
   input  logic [rv_pkg::XLEN-1:0]   alu_m_i,
   input  logic [rv_pkg::XLEN-1:0]   store_data_m_i,
   input  logic [rv_pkg::REG_AW-1:0] rd_m_i,
   input  logic                      reg_write_m_i,
   input  logic                      mem_write_m_i,
   input  rv_pkg::wb_sel_e           wb_sel_m_i,
   input  logic [rv_pkg::XLEN-1:0]   pc4_m_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  logic [rv_pkg::APB_AW-1:0] paddr_i,
   input  logic [rv_pkg::XLEN-1:0]   pwdata_i,
   output logic                      wb_we_o,
   output logic [rv_pkg::REG_AW-1:0] wb_rd_o,
   output logic [rv_pkg::XLEN-1:0]   wb_data_o,
   output logic                      imem_we_o,
   output logic [rv_pkg::APB_AW-5:0] imem_waddr_o,
   output logic [rv_pkg::XLEN-1:0]   imem_wdata_o,
   output logic [rv_pkg::XLEN-1:0]   prdata_o,
   output logic                      pready_o
);

   import rv_pkg::*;

   localparam int DIDX_W = $clog2(DMEM_WORDS);

   logic [XLEN-1:0]   dmem [DMEM_WORDS];
   logic [DIDX_W-1:0] core_idx;
   logic [DIDX_W-1:0] apb_idx;
   logic              setup_q;    // setup phase seen, access pending
   logic              apb_done;
   logic              apb_dsel;

   assign core_idx = alu_m_i[DIDX_W+1:2];
   assign apb_idx  = paddr_i[DIDX_W+1:2];
   assign apb_dsel = paddr_i[10];          // 1 data, 0 instruction memory

   assign pready_o = !run_i;   // hold off the bus while the core runs
   assign apb_done = psel_i && penable_i && pready_o && setup_q;

   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         setup_q <= 1'b0;
      end else if (psel_i && !penable_i) begin
         setup_q <= 1'b1;
      end else if (apb_done) begin
         setup_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (mem_write_m_i) begin
         dmem[core_idx] <= store_data_m_i;
      end
      if (apb_done && pwrite_i && apb_dsel) begin
         dmem[apb_idx] <= pwdata_i;
      end
   end

   assign prdata_o = (apb_done && !pwrite_i && apb_dsel) ? dmem[apb_idx] : '0;

   // instruction memory lives in fetch
   assign imem_we_o    = apb_done && pwrite_i && !apb_dsel;
   assign imem_waddr_o = paddr_i[APB_AW-3:2];
   assign imem_wdata_o = pwdata_i;

   assign wb_we_o = reg_write_m_i;
   assign wb_rd_o = rd_m_i;

   always_comb begin
      case (wb_sel_m_i)
         WB_MEM:  wb_data_o = dmem[core_idx];
         WB_PC4:  wb_data_o = pc4_m_i;
         default: wb_data_o = alu_m_i;
      endcase
   end

endmodule

/* logic/rv_pkg.sv */
// word-only rv32i subset; apb word index is paddr[9:2], paddr[10] selects data memory
package rv_pkg;

   parameter int XLEN   = 32;   // data and address width
   parameter int REG_AW = 5;    // register index width
   parameter int APB_AW = 12;   // apb address width

   // kept major opcodes
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_PASS_B     // lui takes the immediate as is
   } alu_op_e;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_PC4
   } wb_sel_e;

   typedef enum logic [1:0] {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_LT           // signed
   } br_kind_e;

   // addi x0,x0,0
   parameter logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* logic/rv_regfile.sv */
// two combinational read ports and one write port; x0 reads zero and ignores writes
`timescale 1ns/100ps

module rv_regfile (
   input  logic                      clk_i,
   input  logic                      t_intr,
   input  logic                      we_i,
   input  logic [rv_pkg::REG_AW-1:0] waddr_i,
   input  logic [rv_pkg::XLEN-1:0]   wdata_i,
   input  logic [rv_pkg::REG_AW-1:0] raddr1_i,
   input  logic [rv_pkg::REG_AW-1:0] raddr2_i,
   output logic [rv_pkg::XLEN-1:0]   rdata1_o,
   output logic [rv_pkg::XLEN-1:0]   rdata2_o
);

   import rv_pkg::*;

   logic [XLEN-1:0] regs [1:31];   // x0 has no storage

   always_ff @(posedge clk_i or posedge t_intr) begin
      if (t_intr) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && waddr_i != '0) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
   assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f build.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if grep -qx "Everything OK" <<< "$out"; then
   exit 0
else
   exit 1
fi

/* verif/tb_top.sv */
// directed tests read their results back over apb as stored words and only while run_i is low
`timescale 1ns/100ps

module tb_top;

   localparam int CLK_PERIOD = 20;
   localparam int RUN_CYCLES = 200;   // longest program plus loops fits easily
   localparam int APB_LIMIT  = 50;
   localparam int N_RUNS     = 6;
   localparam int MAX_APB    = 500;
   localparam int APB_CYCLES = 4;      // setup, access, idle, slack
   localparam int WATCHDOG_CYCLES = N_RUNS * (RUN_CYCLES + 8) + MAX_APB * APB_CYCLES + 200;

   // riscv field values
   localparam int OPC_IMM  = 'h13,
                  OPC_LOAD = 'h03,
                  FN_ADD   = 0,
                  FN_SLL   = 1,
                  FN_SLT   = 2,
                  FN_W     = 2,
                  FN_XOR   = 4,
                  FN_SRL   = 5,
                  FN_OR    = 6,
                  FN_AND   = 7,
                  FN_BEQ   = 0,
                  FN_BNE   = 1,
                  FN_BLT   = 4;

   logic        clk_i;
   logic        t_intr;
   logic        run_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [11:0] paddr_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;

   int          errors;
   int          checks;
   string       cur_test;
   logic [31:0] prog [$];
   int          exp_idx [$];
   logic [31:0] exp_val [$];

   rv_core_top #(
      .IMEM_WORDS (256),
      .DMEM_WORDS (256)
   ) uut (
      .clk_i     (clk_i),
      .t_intr    (t_intr),
      .run_i     (run_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   // instruction encoders slice their fields from int arguments
   function automatic logic [31:0] r_type(int f3, int f7, int rd, int rs1, int rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(int opc, int f3, int rd, int rs1, int imm);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
   endfunction

   function automatic logic [31:0] s_type(int rs2, int rs1, int off);   // sw only
      return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] u_type(int rd, int hi20);
      return {hi20[19:0], rd[4:0], 7'b0110111};
   endfunction

   function automatic logic [31:0] j_type(int rd, int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
   endfunction

   function automatic logic [31:0] slt(logic [31:0] x, logic [31:0] y);
      return {31'b0, $signed(x) < $signed(y)};
   endfunction

   function automatic logic [11:0] imem_addr(int idx);
      return {2'b00, idx[7:0], 2'b00};
   endfunction

   function automatic logic [11:0] dmem_addr(int idx);
      return {2'b01, idx[7:0], 2'b00};   // bit 10 picks data memory
   endfunction

   function automatic logic [31:0] guard_word(int idx);
      return {16'hC0DE, idx[15:0]};
   endfunction

   task automatic pulse_reset();
      @(posedge clk_i);
      t_intr <= 1'b1;
      repeat (2) @(posedge clk_i);
      t_intr <= 1'b0;
   endtask

   task automatic apb_start(input logic wr, input logic [11:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= wr;
      paddr_i   <= addr;
      pwdata_i  <= data;
      @(posedge clk_i);
      penable_i <= 1'b1;
   endtask

   // pready is sampled mid-cycle and the access completes at the next rising edge
   task automatic apb_finish(output logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge clk_i);
      while (!pready_o && waited < APB_LIMIT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!pready_o) begin
         errors++;
         $display("apb access to address %h never completed", paddr_i);
      end
      data = prdata_o;
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_start(1'b1, addr, data);
      apb_finish(unused);
   endtask

   task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
      apb_start(1'b0, addr, 32'd0);
      apb_finish(data);
   endtask

   task automatic emit(input logic [31:0] instr);
      prog.push_back(instr);
   endtask

   task automatic expect_word(input int idx, input logic [31:0] value);
      exp_idx.push_back(idx);
      exp_val.push_back(value);
   endtask

   // lui then addi with the upper part rounded so the sign-extended low part adds back
   task automatic push_li(input int rd, input logic [31:0] v);
      logic [31:0] lo;
      logic [31:0] hi;
      lo = {{20{v[11]}}, v[11:0]};
      hi = v - lo;
      emit(u_type(rd, int'(hi[31:12])));
      emit(i_type(OPC_IMM, FN_ADD, rd, rd, int'(lo)));
   endtask

   task automatic op_store(input logic [31:0] instr, input int idx, input logic [31:0] value);
      emit(instr);   // result goes to x10
      emit(s_type(10, 0, idx * 4));
      expect_word(idx, value);
   endtask

   task automatic run_program();
      emit(j_type(0, 0));   // spin here once done
      for (int i = 0; i < prog.size(); i++) begin
         apb_write(imem_addr(i), prog[i]);
      end
      pulse_reset();
      run_i <= 1'b1;
      repeat (RUN_CYCLES) @(posedge clk_i);
      run_i <= 1'b0;
      repeat (3) @(posedge clk_i);   // drain
      prog.delete();
   endtask

   task automatic verify_words();
      logic [31:0] got;
      for (int i = 0; i < exp_idx.size(); i++) begin
         apb_read(dmem_addr(exp_idx[i]), got);
         check($sformatf("word %0d", exp_idx[i]), exp_val[i], got);
      end
      exp_idx.delete();
      exp_val.delete();
   endtask

   task automatic test_apb();
      logic [31:0] got;
      logic [31:0] v;
      cur_test = "apb";
      for (int i = 0; i < 8; i++) begin
         v = $urandom();
         apb_write(dmem_addr(200 + i), v);
         expect_word(200 + i, v);
      end
      verify_words();
      // data word at the same index must not show up in an imem read
      apb_write(dmem_addr(3), 32'hA5A5_0003);
      apb_read(imem_addr(3), got);
      check("imem read", 32'd0, got);
      // core spins on a self jump while the access waits
      apb_write(imem_addr(0), j_type(0, 0));
      pulse_reset();
      run_i <= 1'b1;
      apb_start(1'b1, dmem_addr(210), 32'h5A5A_0F0F);
      repeat (4) begin
         @(negedge clk_i);
         check("pready while running", 32'd0, {31'b0, pready_o});
      end
      @(posedge clk_i);
      run_i <= 1'b0;
      apb_finish(got);
      repeat (2) @(posedge clk_i);
      apb_read(dmem_addr(210), got);
      check("word 210", 32'h5A5A_0F0F, got);
   endtask

   task automatic test_arith();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      cur_test = "arith";
      a = 32'h1234_5678;
      b = 32'd5;
      c = 32'h8000_0001;
      push_li(1, a);
      push_li(2, b);
      push_li(3, c);
      op_store(r_type(FN_ADD, 0, 10, 1, 3), 0, a + c);
      op_store(r_type(FN_ADD, 32, 10, 1, 3), 1, a - c);
      op_store(r_type(FN_AND, 0, 10, 1, 3), 2, a & c);
      op_store(r_type(FN_OR, 0, 10, 1, 3), 3, a | c);
      op_store(r_type(FN_XOR, 0, 10, 1, 3), 4, a ^ c);
      op_store(r_type(FN_SLT, 0, 10, 3, 1), 5, slt(c, a));
      op_store(r_type(FN_SLL, 0, 10, 1, 2), 6, a << b[4:0]);
      op_store(r_type(FN_SRL, 0, 10, 3, 2), 7, c >> b[4:0]);
      op_store(i_type(OPC_IMM, FN_ADD, 10, 1, -100), 8, a + 32'hFFFF_FF9C);
      op_store(i_type(OPC_IMM, FN_AND, 10, 1, 'h0F0), 9, a & 32'h0000_00F0);
      op_store(i_type(OPC_IMM, FN_OR, 10, 3, 'h7FF), 10, c | 32'h0000_07FF);
      op_store(i_type(OPC_IMM, FN_XOR, 10, 1, -1), 11, ~a);
      op_store(i_type(OPC_IMM, FN_SLT, 10, 3, -5), 12, slt(c, 32'hFFFF_FFFB));
      op_store(u_type(10, 'hABCDE), 13, 32'hABCD_E000);
      run_program();
      verify_words();
   endtask

   task automatic test_forward();
      logic [31:0] v5;
      logic [31:0] v6;
      logic [31:0] v7;
      logic [31:0] v8;
      cur_test = "forward";
      v5 = 32'd7 + 32'd3;
      v6 = v5 + v5;
      v7 = v6 - v5;
      v8 = v7 + v6;
      emit(i_type(OPC_IMM, FN_ADD, 5, 0, 7));
      emit(i_type(OPC_IMM, FN_ADD, 5, 5, 3));   // x5 straight from writeback
      emit(r_type(FN_ADD, 0, 6, 5, 5));
      emit(r_type(FN_ADD, 32, 7, 6, 5));
      emit(r_type(FN_ADD, 0, 8, 7, 6));
      emit(s_type(8, 0, 256));
      emit(i_type(OPC_LOAD, FN_W, 9, 0, 256));
      emit(i_type(OPC_IMM, FN_ADD, 9, 9, 1));   // load result used at once
      emit(s_type(9, 0, 260));
      emit(s_type(7, 0, 264));
      expect_word(64, v8);
      expect_word(65, v8 + 32'd1);
      expect_word(66, v7);
      run_program();
      verify_words();
   endtask

   task automatic test_load_store();
      logic [31:0] d [4];
      cur_test = "load_store";
      for (int i = 0; i < 4; i++) begin
         d[i] = $urandom();
         apb_write(dmem_addr(80 + i), d[i]);
         emit(i_type(OPC_LOAD, FN_W, i + 1, 0, (80 + i) * 4));
         expect_word(80 + i, d[i]);   // sources stay intact
      end
      op_store(r_type(FN_ADD, 0, 10, 1, 2), 88, d[0] + d[1]);
      op_store(r_type(FN_XOR, 0, 10, 3, 4), 89, d[2] ^ d[3]);
      op_store(r_type(FN_ADD, 32, 10, 4, 1), 90, d[3] - d[0]);
      emit(s_type(1, 0, 91 * 4));
      expect_word(91, d[0]);
      emit(i_type(OPC_LOAD, FN_W, 11, 0, 88 * 4));   // reload a fresh store
      op_store(i_type(OPC_IMM, FN_ADD, 10, 11, 1), 92, d[0] + d[1] + 32'd1);
      run_program();
      verify_words();
   endtask

   task automatic test_control();
      int link;
      cur_test = "control";
      for (int i = 100; i < 109; i++) begin
         apb_write(dmem_addr(i), guard_word(i));
      end
      emit(i_type(OPC_IMM, FN_ADD, 1, 0, 5));
      emit(i_type(OPC_IMM, FN_ADD, 2, 0, 5));
      emit(i_type(OPC_IMM, FN_ADD, 3, 0, -3));
      emit(b_type(FN_BEQ, 1, 2, 8));   // 5 == 5 so taken
      emit(s_type(1, 0, 400));
      emit(b_type(FN_BNE, 1, 2, 8));
      emit(s_type(1, 0, 404));
      emit(b_type(FN_BLT, 3, 1, 8));   // -3 < 5 signed
      emit(s_type(1, 0, 408));
      emit(b_type(FN_BLT, 1, 3, 8));
      emit(s_type(3, 0, 412));
      emit(b_type(FN_BNE, 1, 3, 8));
      emit(s_type(1, 0, 416));
      emit(b_type(FN_BEQ, 1, 3, 8));
      emit(s_type(2, 0, 420));
      link = 4 * prog.size() + 4;
      emit(j_type(4, 8));
      emit(s_type(1, 0, 424));
      emit(s_type(4, 0, 428));
      // countdown loop body runs three times
      emit(i_type(OPC_IMM, FN_ADD, 5, 0, 3));
      emit(i_type(OPC_IMM, FN_ADD, 6, 6, 2));
      emit(i_type(OPC_IMM, FN_ADD, 5, 5, -1));
      emit(b_type(FN_BNE, 5, 0, -8));
      emit(s_type(6, 0, 432));
      expect_word(100, guard_word(100));
      expect_word(101, 32'd5);
      expect_word(102, guard_word(102));
      expect_word(103, 32'hFFFF_FFFD);
      expect_word(104, guard_word(104));
      expect_word(105, 32'd5);
      expect_word(106, guard_word(106));
      expect_word(107, link);
      expect_word(108, 32'd6);
      run_program();
      verify_words();
   endtask

   task automatic test_random();
      logic [31:0] a;
      logic [31:0] b;
      int base;
      cur_test = "random";
      for (int p = 0; p < 4; p++) begin
         a = $urandom();
         b = $urandom();
         base = 120 + 5 * p;
         push_li(1, a);
         push_li(2, b);
         op_store(r_type(FN_ADD, 0, 10, 1, 2), base, a + b);
         op_store(r_type(FN_ADD, 32, 10, 1, 2), base + 1, a - b);
         op_store(r_type(FN_XOR, 0, 10, 1, 2), base + 2, a ^ b);
         op_store(r_type(FN_SLT, 0, 10, 1, 2), base + 3, slt(a, b));
         op_store(r_type(FN_SRL, 0, 10, 1, 2), base + 4, a >> b[4:0]);
      end
      run_program();
      verify_words();
   endtask

   initial begin
      void'($urandom(10546));
      errors    = 0;
      checks    = 0;
      t_intr    <= 1'b1;
      run_i     <= 1'b0;
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
      paddr_i   <= '0;
      pwdata_i  <= '0;
      repeat (2) @(posedge clk_i);
      t_intr <= 1'b0;
      test_apb();
      test_arith();
      test_forward();
      test_load_store();
      test_control();
      test_random();
      repeat (2) @(posedge clk_i);
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
